// ==== logic/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

	localparam int xlen = 32;

	typedef logic [xlen-1:0] word_t;

	// Major opcodes, instruction bits 6:0
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_BRANCH = 7'b1100011,
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111
	} opcode_e;

	// Field positions inside the instruction word
	localparam int opc_lsb = 0;
	localparam int rd_lsb  = 7;
	localparam int f3_lsb  = 12;
	localparam int rs1_lsb = 15;
	localparam int rs2_lsb = 20;
	localparam int f7_alt  = 30;    // sub / sra select bit

	// funct3 of OP and OP_IMM
	localparam logic [2:0] f3_add  = 3'b000;
	localparam logic [2:0] f3_sll  = 3'b001;
	localparam logic [2:0] f3_slt  = 3'b010;
	localparam logic [2:0] f3_sltu = 3'b011;
	localparam logic [2:0] f3_xor  = 3'b100;
	localparam logic [2:0] f3_sr   = 3'b101;
	localparam logic [2:0] f3_or   = 3'b110;
	localparam logic [2:0] f3_and  = 3'b111;

	// Branch conditions
	localparam logic [2:0] f3_beq = 3'b000;
	localparam logic [2:0] f3_bne = 3'b001;

	// addi x0, x0, 0
	localparam word_t nop_word = 32'h0000_0013;

endpackage

`default_nettype wire

// ==== logic/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

	// Operations the ALU can perform
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA
	} alu_op_e;

	// Operation class from the decoder
	typedef enum logic [1:0] {
		CLS_REG,
		CLS_IMM,
		CLS_ADD_ONLY,
		CLS_BRANCH
	} alu_class_e;

	// First ALU operand
	typedef enum logic [1:0] {
		A_RS1,
		A_PC,
		A_ZERO
	} a_src_e;

endpackage

`default_nettype wire

// ==== logic/decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module decoder (
	input  isa_pkg::word_t       instr,
	output logic                 branch,
	output logic                 branch_ne,
	output logic                 mem_read,
	output logic                 mem_write,
	output logic                 mem_to_reg,
	output logic                 reg_write,
	output logic                 alu_src_imm,
	output pipe_pkg::alu_class_e alu_class,
	output pipe_pkg::a_src_e     a_src,
	output isa_pkg::word_t       imm
);
	import isa_pkg::*;
	import pipe_pkg::*;

	opcode_e    opcode;
	logic [2:0] funct3;

	assign opcode = opcode_e'(instr[opc_lsb +: 7]);
	assign funct3 = instr[f3_lsb +: 3];

	always_comb begin
		// Anything not listed below behaves as a nop
		branch      = 1'b0;
		branch_ne   = 1'b0;
		mem_read    = 1'b0;
		mem_write   = 1'b0;
		mem_to_reg  = 1'b0;
		reg_write   = 1'b0;
		alu_src_imm = 1'b0;
		alu_class   = CLS_ADD_ONLY;
		a_src       = A_RS1;
		imm         = '0;

		case (opcode)
			OPC_OP: begin
				reg_write = 1'b1;
				alu_class = CLS_REG;
			end
			OPC_OP_IMM: begin
				reg_write   = 1'b1;
				alu_src_imm = 1'b1;
				alu_class   = CLS_IMM;
				imm         = {{21{instr[31]}}, instr[30:20]};
			end
			OPC_LOAD: begin
				mem_read    = 1'b1;
				mem_to_reg  = 1'b1;
				reg_write   = 1'b1;
				alu_src_imm = 1'b1;
				imm         = {{21{instr[31]}}, instr[30:20]};
			end
			OPC_STORE: begin
				mem_write   = 1'b1;
				alu_src_imm = 1'b1;
				imm         = {{21{instr[31]}}, instr[30:25], instr[11:7]};
			end
			OPC_BRANCH: begin
				// Only beq and bne are supported
				branch    = (funct3 == f3_beq) || (funct3 == f3_bne);
				branch_ne = (funct3 == f3_bne);
				alu_class = CLS_BRANCH;
				imm       = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
			end
			OPC_LUI: begin
				reg_write   = 1'b1;
				alu_src_imm = 1'b1;
				a_src       = A_ZERO;
				imm         = {instr[31:12], 12'b0};
			end
			OPC_AUIPC: begin
				reg_write   = 1'b1;
				alu_src_imm = 1'b1;
				a_src       = A_PC;
				imm         = {instr[31:12], 12'b0};
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  pipe_pkg::alu_class_e alu_class,
	input  logic [3:0]           funct,
	input  isa_pkg::word_t       x,
	input  isa_pkg::word_t       y,
	output isa_pkg::word_t       result,
	output logic                 zero
);
	import isa_pkg::*;
	import pipe_pkg::*;

	alu_op_e    op;
	logic [4:0] shamt;

	assign shamt = y[4:0];

	// ALU control from class and {funct7[5], funct3}
	always_comb begin
		op = ALU_ADD;
		if (alu_class == CLS_BRANCH) begin
			op = ALU_SUB;
		end else if (alu_class != CLS_ADD_ONLY) begin
			case (funct[2:0])
				// Bit 30 is part of the immediate for addi
				f3_add:  op = (alu_class == CLS_REG && funct[3]) ? ALU_SUB : ALU_ADD;
				f3_sll:  op = ALU_SLL;
				f3_slt:  op = ALU_SLT;
				f3_sltu: op = ALU_SLTU;
				f3_xor:  op = ALU_XOR;
				f3_sr:   op = funct[3] ? ALU_SRA : ALU_SRL;
				f3_or:   op = ALU_OR;
				f3_and:  op = ALU_AND;
				default: op = ALU_ADD;
			endcase
		end
	end

	always_comb begin
		case (op)
			ALU_SUB:  result = x - y;
			ALU_AND:  result = x & y;
			ALU_OR:   result = x | y;
			ALU_XOR:  result = x ^ y;
			ALU_SLT:  result = word_t'($signed(x) < $signed(y));
			ALU_SLTU: result = word_t'(x < y);
			ALU_SLL:  result = x << shamt;
			ALU_SRL:  result = x >> shamt;
			ALU_SRA:  result = word_t'($signed(x) >>> shamt);
			default:  result = x + y;
		endcase
	end

	assign zero = (result == '0);

endmodule

`default_nettype wire

// ==== logic/regbank.sv ====
`timescale 1ns/1ps
`default_nettype none

module regbank (
	input  logic           clk,
	input  logic           reset,
	input  logic           write_en,
	input  logic [4:0]     rs1,
	input  logic [4:0]     rs2,
	input  logic [4:0]     rd,
	input  isa_pkg::word_t write_data,
	output isa_pkg::word_t read_data1,
	output isa_pkg::word_t read_data2
);
	import isa_pkg::*;

	word_t regs [32];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (write_en && rd != 5'd0) begin
			regs[rd] <= write_data;
		end
	end

	// x0 reads as zero and a register being written reads as the new value
	function automatic word_t read_port(input logic [4:0] sel);
		if (sel == 5'd0)
			return '0;
		else if (write_en && sel == rd)
			return write_data;
		else
			return regs[sel];
	endfunction

	always_comb begin
		read_data1 = read_port(rs1);
		read_data2 = read_port(rs2);
	end

endmodule

`default_nettype wire

// ==== logic/core.sv ====
`timescale 1ns/1ps
`default_nettype none

module core #(
	parameter int imem_words = 256,
	parameter int dmem_words = 256
) (
	input  logic                          clk,
	input  logic                          reset,
	input  isa_pkg::word_t                idata,
	output logic [$clog2(imem_words)-1:0] iaddr,
	input  isa_pkg::word_t                ddata_r,
	output logic [$clog2(dmem_words)-1:0] daddr,
	output isa_pkg::word_t                ddata_w,
	output logic                          mem_write
);
	import isa_pkg::*;
	import pipe_pkg::*;

	localparam int iaw = $clog2(imem_words);
	localparam int daw = $clog2(dmem_words);

	word_t pc, pc_plus4, pc_next;
	word_t pc_id, instr_id;
	logic  branch_taken;

	// ID stage outputs
	logic       branch_id, branch_ne_id, mem_read_id, mem_write_id;
	logic       mem_to_reg_id, reg_write_id, alu_src_imm_id;
	alu_class_e alu_class_id;
	a_src_e     a_src_id;
	word_t      imm_id, rs1_data_id, rs2_data_id;
	logic [3:0] funct_id;

	// ID/EX
	logic       branch_ex, branch_ne_ex, mem_read_ex, mem_write_ex;
	logic       mem_to_reg_ex, reg_write_ex, alu_src_imm_ex;
	alu_class_e alu_class_ex;
	a_src_e     a_src_ex;
	word_t      pc_ex, imm_ex, rs1_data_ex, rs2_data_ex;
	logic [3:0] funct_ex;
	logic [4:0] rd_ex;
	word_t      alu_x, alu_y, alu_result_ex, target_ex;
	logic       zero_ex;

	// EX/MEM and MEM/WB
	logic       branch_mem, branch_ne_mem, mem_read_mem, mem_write_mem;
	logic       mem_to_reg_mem, reg_write_mem, zero_mem;
	word_t      alu_result_mem, target_mem, rs2_data_mem;
	logic [4:0] rd_mem, rd_wb;
	logic       mem_to_reg_wb, reg_write_wb;
	word_t      alu_result_wb, load_wb, wb_data;

	// -------------------------------------------------------------------------
	// IF
	// -------------------------------------------------------------------------
	assign pc_plus4 = pc + 32'd4;
	assign pc_next  = branch_taken ? target_mem : pc_plus4;
	assign iaddr    = pc[iaw+1:2];

	always_ff @(posedge clk) begin
		if (reset)
			pc <= '0;
		else
			pc <= pc_next;
	end

	always_ff @(posedge clk) begin
		if (reset || branch_taken)
			instr_id <= nop_word;
		else
			instr_id <= idata;
		pc_id <= pc;
	end

	// -------------------------------------------------------------------------
	// ID
	// -------------------------------------------------------------------------
	decoder decoder_inst (
		.instr       (instr_id),
		.branch      (branch_id),
		.branch_ne   (branch_ne_id),
		.mem_read    (mem_read_id),
		.mem_write   (mem_write_id),
		.mem_to_reg  (mem_to_reg_id),
		.reg_write   (reg_write_id),
		.alu_src_imm (alu_src_imm_id),
		.alu_class   (alu_class_id),
		.a_src       (a_src_id),
		.imm         (imm_id)
	);

	regbank regbank_inst (
		.clk        (clk),
		.reset      (reset),
		.write_en   (reg_write_wb),
		.rs1        (instr_id[rs1_lsb +: 5]),
		.rs2        (instr_id[rs2_lsb +: 5]),
		.rd         (rd_wb),
		.write_data (wb_data),
		.read_data1 (rs1_data_id),
		.read_data2 (rs2_data_id)
	);

	assign funct_id = {instr_id[f7_alt], instr_id[f3_lsb +: 3]};

	// Clearing the control bits turns the slot into a nop
	always_ff @(posedge clk) begin
		if (reset || branch_taken) begin
			{branch_ex, branch_ne_ex, mem_read_ex} <= '0;
			{mem_write_ex, mem_to_reg_ex, reg_write_ex} <= '0;
		end else begin
			{branch_ex, branch_ne_ex, mem_read_ex} <= {branch_id, branch_ne_id, mem_read_id};
			mem_write_ex  <= mem_write_id;
			mem_to_reg_ex <= mem_to_reg_id;
			reg_write_ex  <= reg_write_id;
		end
	end

	always_ff @(posedge clk) begin
		alu_src_imm_ex <= alu_src_imm_id;
		alu_class_ex   <= alu_class_id;
		a_src_ex       <= a_src_id;
		funct_ex       <= funct_id;
		pc_ex          <= pc_id;
		imm_ex         <= imm_id;
		rs1_data_ex    <= rs1_data_id;
		rs2_data_ex    <= rs2_data_id;
		rd_ex          <= instr_id[rd_lsb +: 5];
	end

	// -------------------------------------------------------------------------
	// EX
	// -------------------------------------------------------------------------
	always_comb begin
		case (a_src_ex)
			A_PC:    alu_x = pc_ex;
			A_ZERO:  alu_x = '0;
			default: alu_x = rs1_data_ex;
		endcase
	end

	assign alu_y     = alu_src_imm_ex ? imm_ex : rs2_data_ex;
	assign target_ex = pc_ex + imm_ex;

	alu alu_inst (
		.alu_class (alu_class_ex),
		.funct     (funct_ex),
		.x         (alu_x),
		.y         (alu_y),
		.result    (alu_result_ex),
		.zero      (zero_ex)
	);

	always_ff @(posedge clk) begin
		if (reset || branch_taken) begin
			{branch_mem, branch_ne_mem, mem_read_mem} <= '0;
			{mem_write_mem, mem_to_reg_mem, reg_write_mem} <= '0;
		end else begin
			{branch_mem, branch_ne_mem, mem_read_mem} <= {branch_ex, branch_ne_ex, mem_read_ex};
			mem_write_mem  <= mem_write_ex;
			mem_to_reg_mem <= mem_to_reg_ex;
			reg_write_mem  <= reg_write_ex;
		end
	end

	always_ff @(posedge clk) begin
		alu_result_mem <= alu_result_ex;
		zero_mem       <= zero_ex;
		target_mem     <= target_ex;
		rs2_data_mem   <= rs2_data_ex;
		rd_mem         <= rd_ex;
	end

	// -------------------------------------------------------------------------
	// MEM and WB
	// -------------------------------------------------------------------------
	// beq takes on zero, bne on not zero
	assign branch_taken = branch_mem & (zero_mem ^ branch_ne_mem);

	assign daddr     = alu_result_mem[daw+1:2];
	assign ddata_w   = rs2_data_mem;
	assign mem_write = mem_write_mem;

	always_ff @(posedge clk) begin
		if (reset) begin
			reg_write_wb  <= 1'b0;
			mem_to_reg_wb <= 1'b0;
		end else begin
			reg_write_wb  <= reg_write_mem;
			mem_to_reg_wb <= mem_to_reg_mem;
		end
	end

	always_ff @(posedge clk) begin
		alu_result_wb <= alu_result_mem;
		rd_wb         <= rd_mem;
		if (mem_read_mem)
			load_wb <= ddata_r;
	end

	assign wb_data = mem_to_reg_wb ? load_wb : alu_result_wb;

endmodule

`default_nettype wire

// ==== logic/instr_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_mem #(
	parameter int imem_words = 256
) (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          prog_we,
	input  logic [$clog2(imem_words)-1:0] prog_addr,
	input  isa_pkg::word_t                prog_data,
	input  logic [$clog2(imem_words)-1:0] iaddr,
	output isa_pkg::word_t                idata
);
	import isa_pkg::*;

	word_t mem [imem_words];

	// Program load is only possible while the core is held in reset
	always_ff @(posedge clk) begin
		if (reset && prog_we)
			mem[prog_addr] <= prog_data;
	end

	assign idata = mem[iaddr];

endmodule

`default_nettype wire

// ==== logic/data_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_mem #(
	parameter int dmem_words = 256
) (
	input  logic                          clk,
	input  logic                          mem_write,
	input  logic [$clog2(dmem_words)-1:0] daddr,
	input  isa_pkg::word_t                ddata_w,
	output isa_pkg::word_t                ddata_r
);
	import isa_pkg::*;

	word_t mem [dmem_words];

	always_ff @(posedge clk) begin
		if (mem_write)
			mem[daddr] <= ddata_w;
	end

	// Read data follows daddr in the same cycle
	assign ddata_r = mem[daddr];

endmodule

`default_nettype wire

// ==== logic/soc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_top #(
	parameter int imem_words = 256,
	parameter int dmem_words = 256
) (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          prog_we,
	input  logic [$clog2(imem_words)-1:0] prog_addr,
	input  isa_pkg::word_t                prog_data,
	output logic                          store_valid,
	output isa_pkg::word_t                store_addr,
	output isa_pkg::word_t                store_data
);
	import isa_pkg::*;

	localparam int iaw = $clog2(imem_words);
	localparam int daw = $clog2(dmem_words);

	logic [iaw-1:0] iaddr;
	logic [daw-1:0] daddr;
	word_t          idata;
	word_t          ddata_r;
	word_t          ddata_w;
	logic           mem_write;

	core #(
		.imem_words (imem_words),
		.dmem_words (dmem_words)
	) core_inst (
		.clk       (clk),
		.reset     (reset),
		.idata     (idata),
		.iaddr     (iaddr),
		.ddata_r   (ddata_r),
		.daddr     (daddr),
		.ddata_w   (ddata_w),
		.mem_write (mem_write)
	);

	instr_mem #(
		.imem_words (imem_words)
	) instr_mem_inst (
		.clk       (clk),
		.reset     (reset),
		.prog_we   (prog_we),
		.prog_addr (prog_addr),
		.prog_data (prog_data),
		.iaddr     (iaddr),
		.idata     (idata)
	);

	data_mem #(
		.dmem_words (dmem_words)
	) data_mem_inst (
		.clk       (clk),
		.mem_write (mem_write),
		.daddr     (daddr),
		.ddata_w   (ddata_w),
		.ddata_r   (ddata_r)
	);

	// Observation of the MEM-stage store, word index back to a byte address
	assign store_valid = mem_write;
	assign store_addr  = {{(xlen-daw-2){1'b0}}, daddr, 2'b00};
	assign store_data  = ddata_w;

endmodule

`default_nettype wire

// ==== testbench/core_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_sva (
	input logic           clk,
	input logic           reset,
	input logic           mem_write,
	input isa_pkg::word_t pc
);

	// Number of assertion failures so far
	int failures = 0;

	// The reset edge clears the MEM-stage store strobe
	property p_no_store_after_reset;
		@(posedge clk) reset |=> !mem_write;
	endproperty

	a_no_store_after_reset: assert property (p_no_store_after_reset)
		else begin
			$error("mem_write high in the cycle after reset");
			failures++;
		end

	a_pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
		else begin
			$error("PC not word aligned: %h", pc);
			failures++;
		end

	a_store_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(mem_write))
		else begin
			$error("mem_write is unknown");
			failures++;
		end

endmodule

bind core core_sva core_sva_inst (
	.clk       (clk),
	.reset     (reset),
	.mem_write (mem_write),
	.pc        (pc)
);

`default_nettype wire

// ==== testbench/soc_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_tb;
	import isa_pkg::*;

	localparam int imem_words = 256;
	localparam int dmem_words = 256;
	localparam int iaw = $clog2(imem_words);
	localparam word_t addr_mask = word_t'(dmem_words * 4 - 4);
	localparam logic [2:0] f3_word = 3'b010;
	localparam int store_timeout = 4000;
	localparam int quiet_cycles = 60;

	logic           clk;
	logic           reset;
	logic           prog_we;
	logic [iaw-1:0] prog_addr;
	word_t          prog_data;
	logic           store_valid;
	word_t          store_addr;
	word_t          store_data;

	word_t prog [$];
	word_t exp_addr [$];
	word_t exp_data [$];
	int    store_idx;
	int    next_slot;
	int    value_errors;
	int    extra_errors;
	int    timeout_errors;

	soc_top #(
		.imem_words (imem_words),
		.dmem_words (dmem_words)
	) uut (
		.clk         (clk),
		.reset       (reset),
		.prog_we     (prog_we),
		.prog_addr   (prog_addr),
		.prog_data   (prog_data),
		.store_valid (store_valid),
		.store_addr  (store_addr),
		.store_data  (store_data)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ------------------------------------------------------------------------
	// Instruction encoding
	// ------------------------------------------------------------------------
	function automatic word_t r_op(input logic alt, input logic [2:0] f3,
			input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OPC_OP};
	endfunction

	function automatic word_t i_op(input logic [2:0] f3, input logic [4:0] rd,
			input logic [4:0] rs1, input logic [11:0] imm, input opcode_e opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic word_t s_op(input logic [4:0] rs2, input logic [4:0] rs1,
			input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, f3_word, imm[4:0], OPC_STORE};
	endfunction

	function automatic word_t b_op(input logic [2:0] f3, input logic [4:0] rs1,
			input logic [4:0] rs2, input logic [12:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
	endfunction

	function automatic word_t u_op(input opcode_e opc, input logic [4:0] rd,
			input logic [19:0] imm);
		return {imm, rd, opc};
	endfunction

	// Each store of a program goes to its own word
	function automatic logic [11:0] next_offset();
		logic [11:0] off;
		off = 12'(next_slot * 4);
		next_slot++;
		return off;
	endfunction

	task automatic new_program();
		prog.delete();
		next_slot = 0;
	endtask

	// Three nops keep the pipeline free of hazards
	task automatic emit(input word_t instr);
		prog.push_back(instr);
		repeat (3) prog.push_back(nop_word);
	endtask

	task automatic load_const(input logic [4:0] rd, input word_t value);
		word_t upper;
		upper = value + 32'h800;
		emit(u_op(OPC_LUI, rd, upper[31:12]));
		emit(i_op(f3_add, rd, rd, value[11:0], OPC_OP_IMM));
	endtask

	task automatic store_reg(input logic [4:0] rs2);
		emit(s_op(rs2, 5'd0, next_offset()));
	endtask

	task automatic end_program();
		emit(b_op(f3_beq, 5'd0, 5'd0, 13'd0));
	endtask

	// ------------------------------------------------------------------------
	// Reference instruction-set model
	// ------------------------------------------------------------------------
	function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
			input word_t a, input word_t b);
		case (f3)
			f3_add:  if (alt) return a - b; else return a + b;
			f3_sll:  return a << b[4:0];
			f3_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			f3_sltu: return (a < b) ? 32'd1 : 32'd0;
			f3_xor:  return a ^ b;
			f3_sr:   if (alt) return $signed(a) >>> b[4:0]; else return a >> b[4:0];
			f3_or:   return a | b;
			default: return a & b;
		endcase
	endfunction

	// Runs prog sequentially and fills the expected store stream
	function automatic int ref_model();
		word_t      regs [32];
		word_t      dmem [word_t];
		word_t      pc, next_pc, ins, a, b, res, ea;
		word_t      imm_i, imm_s, imm_b, imm_u;
		logic [2:0] f3;
		logic [4:0] rd;
		logic       wb, taken, done;
		int         steps;

		exp_addr.delete();
		exp_data.delete();
		for (int i = 0; i < 32; i++) begin
			regs[i] = '0;
		end
		pc = '0;
		done = 1'b0;
		steps = 0;
		while (!done && steps < 10000) begin
			ins = (pc[31:2] < prog.size()) ? prog[pc[31:2]] : nop_word;
			f3 = ins[14:12];
			rd = ins[11:7];
			a = regs[ins[19:15]];
			b = regs[ins[24:20]];
			imm_i = {{20{ins[31]}}, ins[31:20]};
			imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
			imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
			imm_u = {ins[31:12], 12'b0};
			next_pc = pc + 32'd4;
			wb = 1'b0;
			res = '0;
			case (ins[6:0])
				OPC_OP: begin
					res = alu_ref(f3, ins[30], a, b);
					wb = 1'b1;
				end
				OPC_OP_IMM: begin
					// Bit 30 selects srai only and is an immediate bit otherwise
					res = alu_ref(f3, ins[30] && f3 == f3_sr, a, imm_i);
					wb = 1'b1;
				end
				OPC_LOAD: begin
					ea = (a + imm_i) & addr_mask;
					res = dmem.exists(ea) ? dmem[ea] : '0;
					wb = 1'b1;
				end
				OPC_STORE: begin
					ea = (a + imm_s) & addr_mask;
					dmem[ea] = b;
					exp_addr.push_back(ea);
					exp_data.push_back(b);
				end
				OPC_BRANCH: begin
					taken = (f3 == f3_beq && a == b) || (f3 == f3_bne && a != b);
					if (taken) begin
						next_pc = pc + imm_b;
						done = (imm_b == '0);
					end
				end
				OPC_LUI: begin
					res = imm_u;
					wb = 1'b1;
				end
				OPC_AUIPC: begin
					res = pc + imm_u;
					wb = 1'b1;
				end
				default: begin
				end
			endcase
			if (wb && rd != 5'd0)
				regs[rd] = res;
			pc = next_pc;
			steps++;
		end
		return exp_addr.size();
	endfunction

	// ------------------------------------------------------------------------
	// Store monitor and checks
	// ------------------------------------------------------------------------
	task automatic check_store(input int idx, input word_t got_addr, input word_t got_data,
			input word_t want_addr, input word_t want_data);
		if (got_addr !== want_addr || got_data !== want_data) begin
			$display("ERROR %0t: store %0d wrote %h to %h, expected %h to %h",
				$time, idx, got_data, got_addr, want_data, want_addr);
			value_errors++;
		end
	endtask

	// Outputs are sampled at the edge before the flops update
	always @(posedge clk) begin
		if (!reset && store_valid === 1'b1) begin
			if (store_idx < exp_addr.size()) begin
				check_store(store_idx, store_addr, store_data,
					exp_addr[store_idx], exp_data[store_idx]);
			end else begin
				$display("Extra store at time %0t: %h written to address %h",
					$time, store_data, store_addr);
				extra_errors++;
			end
			store_idx++;
		end
	end

	// ------------------------------------------------------------------------
	// Program run control
	// ------------------------------------------------------------------------
	task automatic start_program(output int count);
		@(negedge clk);
		reset = 1'b1;
		for (int i = 0; i < prog.size(); i++) begin
			@(negedge clk);
			prog_we = 1'b1;
			prog_addr = iaw'(i);
			prog_data = prog[i];
		end
		@(negedge clk);
		prog_we = 1'b0;
		count = ref_model();
		store_idx = 0;
		repeat (2) @(negedge clk);
		reset = 1'b0;
	endtask

	task automatic wait_stores(input int count, input string what);
		int cycles;
		cycles = 0;
		while (store_idx < count && cycles < store_timeout) begin
			@(negedge clk);
			cycles++;
		end
		if (store_idx < count) begin
			$display("Timeout in %s program: only %0d of %0d stores seen",
				what, store_idx, count);
			timeout_errors++;
		end
	endtask

	task automatic run_program(input string what);
		int count;
		start_program(count);
		wait_stores(count, what);
		// Anything stored during this window is an extra store
		repeat (quiet_cycles) @(negedge clk);
	endtask

	// ------------------------------------------------------------------------
	// Programs
	// ------------------------------------------------------------------------
	task automatic build_alu_prog();
		new_program();
		load_const(5'd1, 32'hFFFE_1DC0);
		load_const(5'd2, 32'h0000_0765);
		load_const(5'd3, 32'd5);
		for (int f = 0; f < 8; f++) begin
			emit(r_op(1'b0, 3'(f), 5'd10, 5'd1, (f == 1 || f == 5) ? 5'd3 : 5'd2));
			store_reg(5'd10);
		end
		emit(r_op(1'b1, f3_add, 5'd10, 5'd1, 5'd2));
		store_reg(5'd10);
		emit(r_op(1'b1, f3_sr, 5'd10, 5'd1, 5'd3));
		store_reg(5'd10);
		// Negative operand on the right side
		emit(r_op(1'b0, f3_slt, 5'd10, 5'd2, 5'd1));
		store_reg(5'd10);
		emit(r_op(1'b0, f3_sltu, 5'd10, 5'd2, 5'd1));
		store_reg(5'd10);
		for (int f = 0; f < 8; f++) begin
			emit(i_op(3'(f), 5'd11, 5'd1, (f == 1 || f == 5) ? 12'd7 : 12'hF9C, OPC_OP_IMM));
			store_reg(5'd11);
		end
		emit(i_op(f3_sr, 5'd11, 5'd1, 12'h407, OPC_OP_IMM));
		store_reg(5'd11);
		end_program();
	endtask

	task automatic build_mem_prog();
		new_program();
		load_const(5'd5, 32'hCAFE_1234);
		load_const(5'd7, 32'h0000_0200);
		emit(s_op(5'd5, 5'd0, 12'h100));
		emit(i_op(f3_word, 5'd6, 5'd0, 12'h100, OPC_LOAD));
		store_reg(5'd6);
		emit(i_op(f3_add, 5'd5, 5'd5, 12'h7FF, OPC_OP_IMM));
		emit(s_op(5'd5, 5'd7, 12'hFF8));
		emit(i_op(f3_word, 5'd8, 5'd7, 12'hFF8, OPC_LOAD));
		store_reg(5'd8);
		end_program();
	endtask

	// Branch over three store slots to a marker store
	task automatic branch_case(input word_t br);
		prog.push_back(br);
		repeat (3) prog.push_back(s_op(5'd3, 5'd0, next_offset()));
		store_reg(5'd1);
	endtask

	task automatic build_branch_prog();
		new_program();
		load_const(5'd1, 32'd7);
		load_const(5'd2, 32'd7);
		load_const(5'd3, 32'd9);
		branch_case(b_op(f3_beq, 5'd1, 5'd2, 13'd16));
		branch_case(b_op(f3_bne, 5'd1, 5'd2, 13'd16));
		branch_case(b_op(f3_beq, 5'd1, 5'd3, 13'd16));
		branch_case(b_op(f3_bne, 5'd1, 5'd3, 13'd16));
		end_program();
	endtask

	task automatic build_upper_prog();
		new_program();
		emit(u_op(OPC_LUI, 5'd9, 20'hABCDE));
		store_reg(5'd9);
		emit(u_op(OPC_AUIPC, 5'd10, 20'h12345));
		store_reg(5'd10);
		emit(u_op(OPC_AUIPC, 5'd11, 20'hFFFFF));
		store_reg(5'd11);
		emit(u_op(OPC_LUI, 5'd12, 20'h00001));
		store_reg(5'd12);
		end_program();
	endtask

	task automatic build_random_prog();
		logic [2:0]  f3;
		logic [4:0]  rd, rs1, rs2;
		logic [11:0] imm;
		logic        alt;
		new_program();
		for (int r = 1; r < 7; r++) begin
			load_const(5'(r), $urandom());
		end
		for (int k = 0; k < 12; k++) begin
			f3 = 3'($urandom_range(0, 7));
			rd = 5'($urandom_range(1, 15));
			rs1 = 5'($urandom_range(0, 15));
			rs2 = 5'($urandom_range(0, 15));
			alt = 1'($urandom_range(0, 1));
			imm = 12'($urandom());
			if ($urandom_range(0, 1) == 0) begin
				if (f3 != f3_add && f3 != f3_sr)
					alt = 1'b0;
				emit(r_op(alt, f3, rd, rs1, rs2));
			end else begin
				// Shift immediates carry only a shift amount and the sra bit
				if (f3 == f3_sll)
					imm = {7'b0, imm[4:0]};
				else if (f3 == f3_sr)
					imm = {1'b0, alt, 5'b0, imm[4:0]};
				emit(i_op(f3, rd, rs1, imm, OPC_OP_IMM));
			end
			store_reg(rd);
		end
		end_program();
	endtask

	// ------------------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------------------
	initial begin
		int count;
		int assert_errors;
		void'($urandom(72410));
		reset = 1'b1;
		prog_we = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		store_idx = 0;
		next_slot = 0;
		value_errors = 0;
		extra_errors = 0;
		timeout_errors = 0;

		build_alu_prog();
		run_program("alu");
		build_mem_prog();
		run_program("load/store");
		build_branch_prog();
		run_program("branch");
		build_upper_prog();
		run_program("lui/auipc");
		for (int p = 0; p < 20; p++) begin
			build_random_prog();
			run_program("random");
		end

		// Reset halfway through and run the same program again
		build_alu_prog();
		start_program(count);
		wait_stores(count / 2, "partial");
		run_program("rerun");

		assert_errors = uut.core_inst.core_sva_inst.failures;
		$display("Errors: %0d wrong value, %0d extra store, %0d timeout, %0d assertion",
			value_errors, extra_errors, timeout_errors, assert_errors);
		if (value_errors + extra_errors + timeout_errors + assert_errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== riscv_pipe.f ====
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/decoder.sv
logic/alu.sv
logic/regbank.sv
logic/core.sv
logic/instr_mem.sv
logic/data_mem.sv
logic/soc_top.sv
testbench/core_sva.sv
testbench/soc_tb.sv
